/* manycore_pkg.sv */
package manycore_pkg;

   // tile coordinates
   typedef logic [3:0] x_cord_t;
   typedef logic [3:0] y_cord_t;

   // word address into the endpoint memory
   typedef logic [7:0] addr_t;

   typedef logic [31:0] data_t;

   typedef enum logic [1:0]
   {
      op_store  = 2'd0,
      op_load   = 2'd1,
      op_freeze = 2'd2
   } op_t;

   // dst fields sit in the low bits so the router can read them blind
   typedef struct packed
   {
      op_t     op;
      addr_t   addr;
      data_t   data;
      y_cord_t src_y;
      x_cord_t src_x;
      y_cord_t dst_y;
      x_cord_t dst_x;
   } fwd_packet_t;

   typedef struct packed
   {
      data_t   data;
      logic    is_load;
      y_cord_t dst_y;
      x_cord_t dst_x;
   } rev_packet_t;

   localparam int fwd_width_c = $bits(fwd_packet_t);
   localparam int rev_width_c = $bits(rev_packet_t);

   // router port indices
   localparam int dir_p_c = 0;
   localparam int dir_w_c = 1;
   localparam int dir_e_c = 2;
   localparam int dir_n_c = 3;
   localparam int dir_s_c = 4;
   localparam int dirs_c  = 5;

   // freeze control word, bit 0 of the data is the new level
   localparam addr_t freeze_addr_c = 8'hFF;

endpackage

/* mesh_input_fifo.sv */
`timescale 1ns/1ps

module mesh_input_fifo
#(
    parameter int width_p      = 32
   ,parameter int fifo_depth_p = 2
)
(
    input  logic               clk_i
   ,input  logic               rst_i
   ,input  logic               v_i
   ,input  logic [width_p-1:0] data_i
   ,output logic               ready_o
   ,output logic               v_o
   ,output logic [width_p-1:0] data_o
   ,input  logic               yumi_i
);

   localparam int ptr_w_lp = (fifo_depth_p > 1) ? $clog2(fifo_depth_p) : 1;
   localparam int cnt_w_lp = $clog2(fifo_depth_p + 1);

   logic [width_p-1:0]  mem_r [fifo_depth_p];
   logic [ptr_w_lp-1:0] rd_ptr_r;
   logic [ptr_w_lp-1:0] wr_ptr_r;
   logic [cnt_w_lp-1:0] count_r;
   logic                push;

   function automatic logic [ptr_w_lp-1:0] ptr_inc(input logic [ptr_w_lp-1:0] ptr);
      ptr_inc = (ptr == ptr_w_lp'(fifo_depth_p - 1)) ? '0 : ptr + 1'b1;
   endfunction

   assign ready_o = (count_r != cnt_w_lp'(fifo_depth_p));
   assign v_o     = (count_r != '0);
   assign data_o  = mem_r[rd_ptr_r];
   assign push    = v_i & ready_o;

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         rd_ptr_r <= '0;
         wr_ptr_r <= '0;
         count_r  <= '0;
      end
      else
      begin
         if (push)
         begin
            wr_ptr_r <= ptr_inc(wr_ptr_r);
         end
         if (yumi_i)
         begin
            rd_ptr_r <= ptr_inc(rd_ptr_r);
         end
         count_r <= count_r + cnt_w_lp'(push) - cnt_w_lp'(yumi_i);
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (push)
      begin
         mem_r[wr_ptr_r] <= data_i;
      end
   end

   // sender must hold a stalled entry
   a_hold_stalled: assert property (@(posedge clk_i) disable iff (rst_i)
      v_i && !ready_o |=> v_i && $stable(data_i));

   a_no_pop_empty: assert property (@(posedge clk_i) disable iff (rst_i)
      yumi_i |-> v_o);

endmodule

/* mesh_router_buffered.sv */
`timescale 1ns/1ps

module mesh_router_buffered
#(
    parameter int width_p      = 32
   ,parameter int fifo_depth_p = 2
)
(
    input  logic                                            clk_i
   ,input  logic                                            rst_i
   ,input  manycore_pkg::x_cord_t                           my_x_i
   ,input  manycore_pkg::y_cord_t                           my_y_i
   ,input  logic [manycore_pkg::dirs_c-1:0]                 v_i
   ,input  logic [manycore_pkg::dirs_c-1:0][width_p-1:0]    data_i
   ,output logic [manycore_pkg::dirs_c-1:0]                 ready_o
   ,output logic [manycore_pkg::dirs_c-1:0]                 v_o
   ,output logic [manycore_pkg::dirs_c-1:0][width_p-1:0]    data_o
   ,input  logic [manycore_pkg::dirs_c-1:0]                 ready_i
);

   import manycore_pkg::*;

   localparam int x_w_lp   = $bits(x_cord_t);
   localparam int y_w_lp   = $bits(y_cord_t);
   localparam int sel_w_lp = $clog2(dirs_c);

   logic [dirs_c-1:0]               head_v;
   logic [dirs_c-1:0][width_p-1:0]  head_data;
   logic [dirs_c-1:0]               head_yumi;
   // route[in][out], one hot per valid head
   logic [dirs_c-1:0][dirs_c-1:0]   route;
   logic [dirs_c-1:0][sel_w_lp-1:0] grant_idx;
   logic [dirs_c-1:0]               grant_v;
   logic [dirs_c-1:0]               xfer;

   for (genvar i = 0; i < dirs_c; i++)
   begin : g_in
      x_cord_t dst_x;
      y_cord_t dst_y;

      mesh_input_fifo
      #(
          .width_p      (width_p)
         ,.fifo_depth_p (fifo_depth_p)
      )
      u_fifo
      (
          .clk_i   (clk_i)
         ,.rst_i   (rst_i)
         ,.v_i     (v_i[i])
         ,.data_i  (data_i[i])
         ,.ready_o (ready_o[i])
         ,.v_o     (head_v[i])
         ,.data_o  (head_data[i])
         ,.yumi_i  (head_yumi[i])
      );

      assign dst_x = head_data[i][x_w_lp-1:0];
      assign dst_y = head_data[i][x_w_lp+:y_w_lp];

      // X first, then Y
      always_comb
      begin
         route[i] = '0;
         if (head_v[i])
         begin
            if (dst_x > my_x_i)
               route[i][dir_e_c] = 1'b1;
            else if (dst_x < my_x_i)
               route[i][dir_w_c] = 1'b1;
            else if (dst_y > my_y_i)
               route[i][dir_s_c] = 1'b1;
            else if (dst_y < my_y_i)
               route[i][dir_n_c] = 1'b1;
            else
               route[i][dir_p_c] = 1'b1;
         end
      end
   end

   for (genvar o = 0; o < dirs_c; o++)
   begin : g_out
      logic [sel_w_lp-1:0] ptr_r;
      logic [sel_w_lp-1:0] hold_idx_r;
      logic                hold_r;
      logic [sel_w_lp-1:0] rr_idx;
      logic                rr_v;

      // lowest offset from the pointer wins
      always_comb
      begin
         int cand;
         rr_v   = 1'b0;
         rr_idx = ptr_r;
         for (int k = dirs_c - 1; k >= 0; k--)
         begin
            cand = (int'(ptr_r) + k) % dirs_c;
            if (route[cand][o])
            begin
               rr_v   = 1'b1;
               rr_idx = sel_w_lp'(cand);
            end
         end
      end

      // a stalled grant is held so the output stays put
      assign grant_v[o]   = hold_r | rr_v;
      assign grant_idx[o] = hold_r ? hold_idx_r : rr_idx;
      assign v_o[o]       = grant_v[o];
      assign data_o[o]    = head_data[grant_idx[o]];
      assign xfer[o]      = grant_v[o] & ready_i[o];

      always_ff @(posedge clk_i)
      begin
         if (rst_i)
         begin
            ptr_r  <= '0;
            hold_r <= 1'b0;
         end
         else
         begin
            if (xfer[o])
            begin
               ptr_r <= (grant_idx[o] == sel_w_lp'(dirs_c - 1)) ? '0 : grant_idx[o] + 1'b1;
            end
            hold_r <= grant_v[o] & ~ready_i[o];
         end
      end

      always_ff @(posedge clk_i)
      begin
         hold_idx_r <= grant_idx[o];
      end

      a_out_stable: assert property (@(posedge clk_i) disable iff (rst_i)
         v_o[o] && !ready_i[o] |=> v_o[o] && $stable(data_o[o]));

      // neighbours never send a packet back where it came from
      a_no_uturn: assert property (@(posedge clk_i) disable iff (rst_i)
         v_o[o] |-> grant_idx[o] != sel_w_lp'(o));
   end

   always_comb
   begin
      head_yumi = '0;
      for (int o = 0; o < dirs_c; o++)
      begin
         if (xfer[o])
         begin
            head_yumi[grant_idx[o]] = 1'b1;
         end
      end
   end

endmodule

/* manycore_endpoint.sv */
`timescale 1ns/1ps

module manycore_endpoint
#(
    parameter int mem_words_p = 64
)
(
    input  logic                      clk_i
   ,input  logic                      rst_i
   ,input  manycore_pkg::x_cord_t     my_x_i
   ,input  manycore_pkg::y_cord_t     my_y_i
   ,input  logic                      req_v_i
   ,input  manycore_pkg::fwd_packet_t req_data_i
   ,output logic                      req_ready_o
   ,output logic                      rep_v_o
   ,output manycore_pkg::rev_packet_t rep_data_o
   ,input  logic                      rep_ready_i
   ,output logic                      freeze_o
);

   import manycore_pkg::*;

   localparam int idx_w_lp = (mem_words_p > 1) ? $clog2(mem_words_p) : 1;

   data_t               mem_r [mem_words_p];
   logic [idx_w_lp-1:0] word_idx;
   logic                accept;
   logic                is_load;
   logic                is_ctrl;
   logic                mem_we;
   logic                rep_v_r;
   rev_packet_t         rep_r;
   logic                freeze_r;

   // one reply slot, refilled in the cycle it drains
   assign req_ready_o = ~rep_v_r | rep_ready_i;
   assign accept      = req_v_i & req_ready_o;

   assign word_idx = idx_w_lp'(req_data_i.addr % mem_words_p);
   assign is_load  = (req_data_i.op == op_load);
   assign is_ctrl  = (req_data_i.op == op_freeze) && (req_data_i.addr == freeze_addr_c);
   assign mem_we   = accept && (req_data_i.op == op_store);

   always_ff @(posedge clk_i)
   begin
      if (mem_we)
      begin
         mem_r[word_idx] <= req_data_i.data;
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         rep_v_r  <= 1'b0;
         freeze_r <= 1'b0;
      end
      else
      begin
         if (accept)
            rep_v_r <= 1'b1;
         else if (rep_ready_i)
            rep_v_r <= 1'b0;

         if (accept && is_ctrl)
         begin
            freeze_r <= req_data_i.data[0];
         end
      end
   end

   // reply goes back to the requester
   always_ff @(posedge clk_i)
   begin
      if (accept)
      begin
         rep_r.data    <= is_load ? mem_r[word_idx] : req_data_i.data;
         rep_r.is_load <= is_load;
         rep_r.dst_x   <= req_data_i.src_x;
         rep_r.dst_y   <= req_data_i.src_y;
      end
   end

   assign rep_v_o    = rep_v_r;
   assign rep_data_o = rep_r;
   assign freeze_o   = freeze_r;

   // the fwd router only hands over packets meant for this tile
   a_dst_is_me: assert property (@(posedge clk_i) disable iff (rst_i)
      req_v_i |-> (req_data_i.dst_x == my_x_i) && (req_data_i.dst_y == my_y_i));

endmodule

/* manycore_tile.sv */
`timescale 1ns/1ps

module manycore_tile
#(
    parameter int fifo_depth_p = 2
   ,parameter int mem_words_p  = 64
)
(
    input  logic                                                          clk_i
   ,input  logic                                                          rst_i
   ,input  manycore_pkg::x_cord_t                                         my_x_i
   ,input  manycore_pkg::y_cord_t                                         my_y_i

   ,input  logic [manycore_pkg::dirs_c-1:1]                               fwd_v_i
   ,input  logic [manycore_pkg::dirs_c-1:1][manycore_pkg::fwd_width_c-1:0] fwd_data_i
   ,output logic [manycore_pkg::dirs_c-1:1]                               fwd_ready_o
   ,output logic [manycore_pkg::dirs_c-1:1]                               fwd_v_o
   ,output logic [manycore_pkg::dirs_c-1:1][manycore_pkg::fwd_width_c-1:0] fwd_data_o
   ,input  logic [manycore_pkg::dirs_c-1:1]                               fwd_ready_i

   ,input  logic [manycore_pkg::dirs_c-1:1]                               rev_v_i
   ,input  logic [manycore_pkg::dirs_c-1:1][manycore_pkg::rev_width_c-1:0] rev_data_i
   ,output logic [manycore_pkg::dirs_c-1:1]                               rev_ready_o
   ,output logic [manycore_pkg::dirs_c-1:1]                               rev_v_o
   ,output logic [manycore_pkg::dirs_c-1:1][manycore_pkg::rev_width_c-1:0] rev_data_o
   ,input  logic [manycore_pkg::dirs_c-1:1]                               rev_ready_i

   ,output logic                                                          freeze_o
);

   import manycore_pkg::*;

   logic [dirs_c-1:0]                  fwd_v_li;
   logic [dirs_c-1:0][fwd_width_c-1:0] fwd_data_li;
   logic [dirs_c-1:0]                  fwd_ready_lo;
   logic [dirs_c-1:0]                  fwd_v_lo;
   logic [dirs_c-1:0][fwd_width_c-1:0] fwd_data_lo;
   logic [dirs_c-1:0]                  fwd_ready_li;

   logic [dirs_c-1:0]                  rev_v_li;
   logic [dirs_c-1:0][rev_width_c-1:0] rev_data_li;
   logic [dirs_c-1:0]                  rev_ready_lo;
   logic [dirs_c-1:0]                  rev_v_lo;
   logic [dirs_c-1:0][rev_width_c-1:0] rev_data_lo;
   logic [dirs_c-1:0]                  rev_ready_li;

   logic                               ep_req_ready;
   logic                               ep_rep_v;
   rev_packet_t                        ep_rep_data;

   // port P is index 0, edges sit above it
   // endpoint issues no requests, so fwd P input stays idle
   assign fwd_v_li     = {fwd_v_i, 1'b0};
   assign fwd_data_li  = {fwd_data_i, {fwd_width_c{1'b0}}};
   assign fwd_ready_li = {fwd_ready_i, ep_req_ready};
   assign fwd_ready_o  = fwd_ready_lo[dirs_c-1:1];
   assign fwd_v_o      = fwd_v_lo[dirs_c-1:1];
   assign fwd_data_o   = fwd_data_lo[dirs_c-1:1];

   // nothing consumes replies at P
   assign rev_v_li     = {rev_v_i, ep_rep_v};
   assign rev_data_li  = {rev_data_i, ep_rep_data};
   assign rev_ready_li = {rev_ready_i, 1'b0};
   assign rev_ready_o  = rev_ready_lo[dirs_c-1:1];
   assign rev_v_o      = rev_v_lo[dirs_c-1:1];
   assign rev_data_o   = rev_data_lo[dirs_c-1:1];

   mesh_router_buffered
   #(
       .width_p      (fwd_width_c)
      ,.fifo_depth_p (fifo_depth_p)
   )
   u_fwd_router
   (
       .clk_i   (clk_i)
      ,.rst_i   (rst_i)
      ,.my_x_i  (my_x_i)
      ,.my_y_i  (my_y_i)
      ,.v_i     (fwd_v_li)
      ,.data_i  (fwd_data_li)
      ,.ready_o (fwd_ready_lo)
      ,.v_o     (fwd_v_lo)
      ,.data_o  (fwd_data_lo)
      ,.ready_i (fwd_ready_li)
   );

   mesh_router_buffered
   #(
       .width_p      (rev_width_c)
      ,.fifo_depth_p (fifo_depth_p)
   )
   u_rev_router
   (
       .clk_i   (clk_i)
      ,.rst_i   (rst_i)
      ,.my_x_i  (my_x_i)
      ,.my_y_i  (my_y_i)
      ,.v_i     (rev_v_li)
      ,.data_i  (rev_data_li)
      ,.ready_o (rev_ready_lo)
      ,.v_o     (rev_v_lo)
      ,.data_o  (rev_data_lo)
      ,.ready_i (rev_ready_li)
   );

   manycore_endpoint
   #(
       .mem_words_p (mem_words_p)
   )
   u_endpoint
   (
       .clk_i       (clk_i)
      ,.rst_i       (rst_i)
      ,.my_x_i      (my_x_i)
      ,.my_y_i      (my_y_i)
      ,.req_v_i     (fwd_v_lo[dir_p_c])
      ,.req_data_i  (fwd_data_lo[dir_p_c])
      ,.req_ready_o (ep_req_ready)
      ,.rep_v_o     (ep_rep_v)
      ,.rep_data_o  (ep_rep_data)
      ,.rep_ready_i (rev_ready_lo[dir_p_c])
      ,.freeze_o    (freeze_o)
   );

   // a reply to this tile would stall forever at the idle P output
   a_no_rev_to_p: assert property (@(posedge clk_i) disable iff (rst_i)
      !rev_v_lo[dir_p_c]);

endmodule

/* tb_manycore_tile.sv */
`timescale 1ns/1ps

module tb_manycore_tile;

   import manycore_pkg::*;

   localparam int      mem_words_c = 64;
   localparam int      timeout_c   = 20000;
   localparam x_cord_t my_x_c      = 4'd4;
   localparam y_cord_t my_y_c      = 4'd4;

   logic                               clk;
   logic                               rst;
   logic [dirs_c-1:1]                  fwd_v_in;
   logic [dirs_c-1:1][fwd_width_c-1:0] fwd_data_in;
   logic [dirs_c-1:1]                  fwd_ready_out;
   logic [dirs_c-1:1]                  fwd_v_out;
   logic [dirs_c-1:1][fwd_width_c-1:0] fwd_data_out;
   logic [dirs_c-1:1]                  fwd_ready_in;
   logic [dirs_c-1:1]                  rev_v_in;
   logic [dirs_c-1:1][rev_width_c-1:0] rev_data_in;
   logic [dirs_c-1:1]                  rev_ready_out;
   logic [dirs_c-1:1]                  rev_v_out;
   logic [dirs_c-1:1][rev_width_c-1:0] rev_data_out;
   logic [dirs_c-1:1]                  rev_ready_in;
   logic                               freeze_out;

   int    cycles = 0;
   int    checks = 0;
   int    errors = 0;
   int    errors_at_start = 0;
   int    tests_run = 0;
   int    tests_failed = 0;
   string test_name = "reset";
   data_t ref_mem [mem_words_c];
   logic  ref_valid [mem_words_c];

   manycore_tile
   #(
       .fifo_depth_p (2)
      ,.mem_words_p  (mem_words_c)
   )
   u_manycore_tile
   (
       .clk_i       (clk)
      ,.rst_i       (rst)
      ,.my_x_i      (my_x_c)
      ,.my_y_i      (my_y_c)
      ,.fwd_v_i     (fwd_v_in)
      ,.fwd_data_i  (fwd_data_in)
      ,.fwd_ready_o (fwd_ready_out)
      ,.fwd_v_o     (fwd_v_out)
      ,.fwd_data_o  (fwd_data_out)
      ,.fwd_ready_i (fwd_ready_in)
      ,.rev_v_i     (rev_v_in)
      ,.rev_data_i  (rev_data_in)
      ,.rev_ready_o (rev_ready_out)
      ,.rev_v_o     (rev_v_out)
      ,.rev_data_o  (rev_data_out)
      ,.rev_ready_i (rev_ready_in)
      ,.freeze_o    (freeze_out)
   );

   always #5 clk = ~clk;

   always @(posedge clk)
   begin
      cycles <= cycles + 1;
      if (cycles == timeout_c)
      begin
         $display("timeout: tests did not finish within %0d cycles", timeout_c);
         $display("Simulation failed");
         $finish;
      end
   end

   task automatic check_rev_packet(input rev_packet_t exp, input rev_packet_t act);
      checks++;
      if (act !== exp)
      begin
         errors++;
         $display("mismatch %s: expected %h, actual %h", test_name, exp, act);
      end
   endtask

   task automatic check_fwd_packet(input fwd_packet_t exp, input fwd_packet_t act);
      checks++;
      if (act !== exp)
      begin
         errors++;
         $display("mismatch %s: expected %h, actual %h", test_name, exp, act);
      end
   endtask

   task automatic check_freeze(input logic exp, input logic act);
      checks++;
      if (act !== exp)
      begin
         errors++;
         $display("mismatch %s: expected freeze %b, actual %b", test_name, exp, act);
      end
   endtask

   task automatic start_test(input string name);
      test_name       = name;
      errors_at_start = errors;
   endtask

   task automatic end_test();
      tests_run++;
      if (errors == errors_at_start)
      begin
         $display("test %s: pass", test_name);
      end
      else
      begin
         tests_failed++;
         $display("test %s: FAIL with %0d errors", test_name, errors - errors_at_start);
      end
   endtask

   // reply addressed to the neighbor on side dir
   function automatic rev_packet_t reply_to(input int dir, input data_t data, input logic ld);
      rev_packet_t r;
      r.data    = data;
      r.is_load = ld;
      r.dst_x   = my_x_c;
      r.dst_y   = my_y_c;
      case (dir)
         dir_w_c: r.dst_x = my_x_c - 4'd1;
         dir_e_c: r.dst_x = my_x_c + 4'd1;
         dir_n_c: r.dst_y = my_y_c - 4'd1;
         default: r.dst_y = my_y_c + 4'd1;
      endcase
      return r;
   endfunction

   function automatic fwd_packet_t request_from(input int dir, input op_t op,
                                                input addr_t addr, input data_t data);
      fwd_packet_t p;
      rev_packet_t n;
      n       = reply_to(dir, '0, 1'b0);
      p.op    = op;
      p.addr  = addr;
      p.data  = data;
      p.src_x = n.dst_x;
      p.src_y = n.dst_y;
      p.dst_x = my_x_c;
      p.dst_y = my_y_c;
      return p;
   endfunction

   task automatic send_fwd(input int dir, input fwd_packet_t pkt);
      @(posedge clk);
      fwd_v_in[dir]    <= 1'b1;
      fwd_data_in[dir] <= pkt;
      @(negedge clk);
      while (!fwd_ready_out[dir])
      begin
         @(negedge clk);
      end
      @(posedge clk);
      fwd_v_in[dir] <= 1'b0;
   endtask

   task automatic send_rev(input int dir, input rev_packet_t pkt);
      @(posedge clk);
      rev_v_in[dir]    <= 1'b1;
      rev_data_in[dir] <= pkt;
      @(negedge clk);
      while (!rev_ready_out[dir])
      begin
         @(negedge clk);
      end
      @(posedge clk);
      rev_v_in[dir] <= 1'b0;
   endtask

   task automatic expect_rev(input int dir, input rev_packet_t exp);
      @(posedge clk);
      rev_ready_in[dir] <= 1'b1;
      @(negedge clk);
      while (!rev_v_out[dir])
      begin
         @(negedge clk);
      end
      check_rev_packet(exp, rev_data_out[dir]);
      @(posedge clk);
      rev_ready_in[dir] <= 1'b0;
   endtask

   task automatic expect_fwd(input int dir, input fwd_packet_t exp);
      @(posedge clk);
      fwd_ready_in[dir] <= 1'b1;
      @(negedge clk);
      while (!fwd_v_out[dir])
      begin
         @(negedge clk);
      end
      check_fwd_packet(exp, fwd_data_out[dir]);
      @(posedge clk);
      fwd_ready_in[dir] <= 1'b0;
   endtask

   task automatic store_word(input int dir, input addr_t addr, input data_t data);
      send_fwd(dir, request_from(dir, op_store, addr, data));
      expect_rev(dir, reply_to(dir, data, 1'b0));
      ref_mem[int'(addr) % mem_words_c]   = data;
      ref_valid[int'(addr) % mem_words_c] = 1'b1;
   endtask

   task automatic load_word(input int dir, input addr_t addr);
      data_t exp;
      exp = ref_mem[int'(addr) % mem_words_c];
      // data field of a load is ignored by the endpoint
      send_fwd(dir, request_from(dir, op_load, addr, 32'h0BAD_F00D));
      expect_rev(dir, reply_to(dir, exp, 1'b1));
   endtask

   task automatic freeze_write(input int dir, input logic level);
      send_fwd(dir, request_from(dir, op_freeze, freeze_addr_c, {31'd0, level}));
      expect_rev(dir, reply_to(dir, {31'd0, level}, 1'b0));
      @(negedge clk);
      check_freeze(level, freeze_out);
   endtask

   task automatic fwd_case(input int in_dir, input int out_dir, input x_cord_t dx,
                           input y_cord_t dy);
      fwd_packet_t p;
      p       = request_from(in_dir, op_load, addr_t'($urandom), $urandom);
      p.dst_x = dx;
      p.dst_y = dy;
      send_fwd(in_dir, p);
      expect_fwd(out_dir, p);
   endtask

   task automatic rev_case(input int in_dir, input int out_dir, input x_cord_t dx,
                           input y_cord_t dy);
      rev_packet_t r;
      r.data    = $urandom;
      r.is_load = 1'($urandom % 2);
      r.dst_x   = dx;
      r.dst_y   = dy;
      send_rev(in_dir, r);
      expect_rev(out_dir, r);
   endtask

   task automatic test_store_load();
      data_t d;
      start_test("store_load");
      for (int dir = dir_w_c; dir <= dir_s_c; dir++)
      begin
         d = $urandom;
         store_word(dir, addr_t'(dir * 7), d);
         load_word(dir, addr_t'(dir * 7));
      end
      end_test();
   endtask

   task automatic test_fwd_pass();
      start_test("fwd_pass");
      fwd_case(dir_n_c, dir_e_c, 4'd6, 4'd1);
      fwd_case(dir_w_c, dir_s_c, 4'd4, 4'd7);
      fwd_case(dir_s_c, dir_n_c, 4'd4, 4'd1);
      fwd_case(dir_e_c, dir_w_c, 4'd2, 4'd9);
      fwd_case(dir_s_c, dir_w_c, 4'd0, 4'd4);
      end_test();
   endtask

   task automatic test_rev_pass();
      start_test("rev_pass");
      rev_case(dir_w_c, dir_e_c, 4'd7, 4'd4);
      rev_case(dir_e_c, dir_w_c, 4'd1, 4'd2);
      rev_case(dir_n_c, dir_s_c, 4'd4, 4'd8);
      rev_case(dir_s_c, dir_n_c, 4'd4, 4'd0);
      end_test();
   endtask

   task automatic test_back_pressure();
      fwd_packet_t pkts [10];
      start_test("back_pressure");
      for (int i = 0; i < 10; i++)
      begin
         pkts[i]       = request_from(dir_w_c, op_store, addr_t'(i), $urandom);
         pkts[i].dst_x = 4'd6;
         pkts[i].dst_y = 4'($urandom % 16);
      end
      fork
         begin
            for (int i = 0; i < 10; i++)
            begin
               send_fwd(dir_w_c, pkts[i]);
            end
         end
         begin
            // E output ready stays low until the W FIFO is full
            repeat (30) @(posedge clk);
            @(negedge clk);
            if (fwd_ready_out[dir_w_c])
            begin
               errors++;
               $display("%s: W input still ready while E output is stalled", test_name);
            end
            for (int i = 0; i < 10; i++)
            begin
               expect_fwd(dir_e_c, pkts[i]);
            end
         end
      join
      end_test();
   endtask

   task automatic test_freeze();
      data_t d;
      start_test("freeze");
      d = $urandom;
      @(negedge clk);
      check_freeze(1'b0, freeze_out);
      store_word(dir_w_c, freeze_addr_c, d);
      freeze_write(dir_n_c, 1'b1);
      load_word(dir_e_c, freeze_addr_c);
      freeze_write(dir_s_c, 1'b0);
      load_word(dir_w_c, freeze_addr_c);
      end_test();
   endtask

   task automatic test_random_mix();
      int    dir;
      addr_t addr;
      start_test("random_mix");
      for (int i = 0; i < 200; i++)
      begin
         dir  = dir_w_c + int'($urandom % 4);
         addr = addr_t'($urandom);
         if (ref_valid[int'(addr) % mem_words_c] && ($urandom % 2 == 0))
            load_word(dir, addr);
         else
            store_word(dir, addr, $urandom);
      end
      end_test();
   endtask

   initial
   begin
      void'($urandom(67900));
      clk          = 1'b0;
      rst          = 1'b1;
      fwd_v_in     = '0;
      fwd_data_in  = '0;
      fwd_ready_in = '0;
      rev_v_in     = '0;
      rev_data_in  = '0;
      rev_ready_in = '0;
      for (int i = 0; i < mem_words_c; i++)
      begin
         ref_mem[i]   = '0;
         ref_valid[i] = 1'b0;
      end
      repeat (16) @(posedge clk);
      rst <= 1'b0;

      test_store_load();
      test_fwd_pass();
      test_rev_pass();
      test_back_pressure();
      test_freeze();
      test_random_mix();

      $display("tests run %0d, tests failed %0d, checks %0d, errors %0d",
               tests_run, tests_failed, checks, errors);
      if (errors == 0)
         $display("Simulation completed successfully");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule

/* flist.f */
manycore_pkg.sv
mesh_input_fifo.sv
mesh_router_buffered.sv
manycore_endpoint.sv
manycore_tile.sv
tb_manycore_tile.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the manycore tile testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_manycore_tile -f flist.f -o tb_manycore_tile > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
   cat build.log
   echo "verilator build failed with status $status"
   exit 1
fi

./obj_dir/tb_manycore_tile > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "Simulation failed" sim.log; then
   exit 1
fi
exit 0
